// File: design/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data path and PC width.
`define EX_DATA_W      24

// General-purpose register file.
`define EX_REG_CNT     16
`define EX_REG_IDX_W   4

// Instruction fields.
`define EX_OPC_W       6
`define EX_CC_W        4
`define EX_IMM_W       12

`endif

// File: design/ex_isa_pkg.sv
`include "ex_consts.svh"

package ex_isa_pkg;

    // Bit 4 marks immediate forms, bit 5 marks signed forms.
    typedef enum logic [`EX_OPC_W-1:0] {
        OPC_MOV   = 6'h00,
        OPC_ADD   = 6'h01,
        OPC_SUB   = 6'h02,
        OPC_AND   = 6'h03,
        OPC_OR    = 6'h04,
        OPC_XOR   = 6'h05,
        OPC_SHL   = 6'h06,
        OPC_SHR   = 6'h07,
        OPC_CMP   = 6'h08,
        OPC_JCC   = 6'h09,
        OPC_MOVI  = 6'h10,
        OPC_ADDI  = 6'h11,
        OPC_SUBI  = 6'h12,
        OPC_ANDI  = 6'h13,
        OPC_ORI   = 6'h14,
        OPC_XORI  = 6'h15,
        OPC_CMPI  = 6'h16,
        OPC_ADDS  = 6'h20,
        OPC_SUBS  = 6'h21,
        OPC_MOVIS = 6'h30,
        OPC_ADDIS = 6'h31,
        OPC_SUBIS = 6'h32
    } opcode_e;

    typedef enum logic [`EX_CC_W-1:0] {
        CC_RA = 4'd0,
        CC_EQ = 4'd1,
        CC_NE = 4'd2,
        CC_LT = 4'd3,
        CC_GT = 4'd4,
        CC_GE = 4'd5,
        CC_LE = 4'd6,
        CC_BT = 4'd7,
        CC_AT = 4'd8,
        CC_BE = 4'd9,
        CC_AE = 4'd10
    } cc_e;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`EX_REG_IDX_W-1:0] tgt;
        logic [`EX_REG_IDX_W-1:0] src;
        cc_e                      cc;
        logic [`EX_DATA_W-`EX_OPC_W-2*`EX_REG_IDX_W-`EX_CC_W-1:0] pad;
    } r_form_t;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`EX_REG_IDX_W-1:0] tgt;
        logic [`EX_DATA_W-`EX_OPC_W-`EX_REG_IDX_W-`EX_IMM_W-1:0] pad;
        logic [`EX_IMM_W-1:0]     imm;
    } i_form_t;

    // Same word, two views. Opcode and tgt line up in both.
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_u;

endpackage

// File: design/ex_pipe_pkg.sv
`include "ex_consts.svh"

package ex_pipe_pkg;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

    // Values after bypass and immediate extension.
    typedef struct packed {
        logic [`EX_DATA_W-1:0] src_val;
        logic [`EX_DATA_W-1:0] tgt_val;
        logic [`EX_DATA_W-1:0] imm_val;
    } operands_t;

    typedef struct packed {
        logic                     valid;
        logic                     we;
        logic [`EX_REG_IDX_W-1:0] tgt;
        logic [`EX_DATA_W-1:0]    data;
    } result_t;

    typedef struct packed {
        logic                  taken;
        logic [`EX_DATA_W-1:0] pc;
    } branch_t;

endpackage

// File: design/ex_regfile.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_regfile (
    input  logic                   iw_clk,
    input  logic                   iw_rst,
    input  ex_isa_pkg::instr_u     instr,
    input  ex_pipe_pkg::result_t   wb,
    output ex_pipe_pkg::operands_t operands
);
    logic [`EX_DATA_W-1:0] regs [`EX_REG_CNT];
    logic                  wb_hit_src;
    logic                  wb_hit_tgt;
    logic                  sign_ext;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < `EX_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.we) begin
            regs[wb.tgt] <= wb.data;
        end
    end

    // Result still in write-back wins over the array.
    assign wb_hit_src = wb.valid && wb.we && (wb.tgt == instr.r.src);
    assign wb_hit_tgt = wb.valid && wb.we && (wb.tgt == instr.r.tgt);

    assign operands.src_val = wb_hit_src ? wb.data : regs[instr.r.src];
    assign operands.tgt_val = wb_hit_tgt ? wb.data : regs[instr.r.tgt];

    assign sign_ext = instr.i.opcode inside {ex_isa_pkg::OPC_MOVIS,
                                             ex_isa_pkg::OPC_ADDIS,
                                             ex_isa_pkg::OPC_SUBIS};

    always_comb begin
        if (sign_ext) begin
            operands.imm_val = {{(`EX_DATA_W-`EX_IMM_W){instr.i.imm[`EX_IMM_W-1]}},
                                instr.i.imm};
        end else begin
            operands.imm_val = {{(`EX_DATA_W-`EX_IMM_W){1'b0}}, instr.i.imm};
        end
    end

endmodule

// File: design/ex_alu.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu (
    input  ex_isa_pkg::instr_u     instr,
    input  logic                   instr_valid,
    input  logic [`EX_DATA_W-1:0]  pc,
    input  ex_pipe_pkg::operands_t operands,
    input  ex_pipe_pkg::flags_t    flags,
    output ex_pipe_pkg::result_t   next_result,
    output ex_pipe_pkg::flags_t    next_flags,
    output ex_pipe_pkg::branch_t   next_branch
);
    localparam int MSB = `EX_DATA_W - 1;

    logic [`EX_DATA_W-1:0] tgt;
    logic [`EX_DATA_W-1:0] opb;
    logic [`EX_DATA_W:0]   wide;
    logic [`EX_DATA_W-1:0] res;
    logic                  wr_en;
    logic                  upd_z;
    logic                  is_jcc;
    logic                  cc_hit;
    ex_pipe_pkg::flags_t   fl;

    assign tgt = operands.tgt_val;
    assign opb = instr.r.opcode[4] ? operands.imm_val : operands.src_val; // Imm forms.

    // Condition test on the architectural flags.
    always_comb begin
        case (instr.r.cc)
            ex_isa_pkg::CC_RA: cc_hit = 1'b1;
            ex_isa_pkg::CC_EQ: cc_hit = flags.z;
            ex_isa_pkg::CC_NE: cc_hit = ~flags.z;
            ex_isa_pkg::CC_LT: cc_hit = flags.n ^ flags.v;
            ex_isa_pkg::CC_GT: cc_hit = ~flags.z & ~(flags.n ^ flags.v);
            ex_isa_pkg::CC_GE: cc_hit = ~(flags.n ^ flags.v);
            ex_isa_pkg::CC_LE: cc_hit = flags.z | (flags.n ^ flags.v);
            ex_isa_pkg::CC_BT: cc_hit = flags.c;
            ex_isa_pkg::CC_AT: cc_hit = ~flags.z & ~flags.c;
            ex_isa_pkg::CC_BE: cc_hit = flags.c | flags.z;
            ex_isa_pkg::CC_AE: cc_hit = ~flags.c;
            default:           cc_hit = 1'b0;
        endcase
    end

    always_comb begin
        wide   = '0;
        res    = '0;
        wr_en  = 1'b1;
        upd_z  = 1'b1;
        is_jcc = 1'b0;
        fl     = flags;
        case (instr.r.opcode)
            ex_isa_pkg::OPC_MOV, ex_isa_pkg::OPC_MOVI: begin
                res = opb;
            end
            ex_isa_pkg::OPC_ADD, ex_isa_pkg::OPC_ADDI: begin
                wide = {1'b0, tgt} + {1'b0, opb};
                res  = wide[MSB:0];
                fl.c = wide[`EX_DATA_W];  // Carry out.
            end
            ex_isa_pkg::OPC_SUB, ex_isa_pkg::OPC_SUBI,
            ex_isa_pkg::OPC_CMP, ex_isa_pkg::OPC_CMPI: begin
                wide  = {1'b0, tgt} - {1'b0, opb};
                res   = wide[MSB:0];
                fl.c  = wide[`EX_DATA_W];  // Borrow.
                wr_en = (instr.r.opcode == ex_isa_pkg::OPC_SUB) ||
                        (instr.r.opcode == ex_isa_pkg::OPC_SUBI);
            end
            ex_isa_pkg::OPC_AND, ex_isa_pkg::OPC_ANDI: res = tgt & opb;
            ex_isa_pkg::OPC_OR,  ex_isa_pkg::OPC_ORI:  res = tgt | opb;
            ex_isa_pkg::OPC_XOR, ex_isa_pkg::OPC_XORI: res = tgt ^ opb;
            ex_isa_pkg::OPC_SHL, ex_isa_pkg::OPC_SHR: begin
                if (opb >= `EX_DATA_W) begin
                    res  = '0;
                    fl.v = 1'b1;  // Shifted out entirely.
                end else begin
                    if (instr.r.opcode == ex_isa_pkg::OPC_SHL)
                        res = tgt << opb[4:0];
                    else
                        res = tgt >> opb[4:0];
                    fl.v = 1'b0;
                end
            end
            ex_isa_pkg::OPC_MOVIS: begin
                res  = opb;
                fl.n = res[MSB];
                fl.v = 1'b0;
            end
            ex_isa_pkg::OPC_ADDS, ex_isa_pkg::OPC_ADDIS: begin
                res  = tgt + opb;
                fl.n = res[MSB];
                fl.v = (tgt[MSB] == opb[MSB]) && (res[MSB] != tgt[MSB]);
            end
            ex_isa_pkg::OPC_SUBS, ex_isa_pkg::OPC_SUBIS: begin
                res  = tgt - opb;
                fl.n = res[MSB];
                fl.v = (tgt[MSB] != opb[MSB]) && (res[MSB] != tgt[MSB]);
            end
            ex_isa_pkg::OPC_JCC: begin
                is_jcc = 1'b1;
                wr_en  = 1'b0;
                upd_z  = 1'b0;
            end
            default: begin
                wr_en = 1'b0;
                upd_z = 1'b0;
            end
        endcase
        if (upd_z)
            fl.z = (res == '0);
    end

    // Nothing leaves the ALU without a strobe.
    always_comb begin
        next_result = '0;
        next_branch = '0;
        next_flags  = flags;
        if (instr_valid) begin
            next_result.valid = 1'b1;
            next_result.we    = wr_en;
            next_result.tgt   = instr.r.tgt;
            next_result.data  = res;
            next_flags        = fl;
            if (is_jcc && cc_hit) begin
                next_branch.taken = 1'b1;
                next_branch.pc    = pc + operands.src_val;  // PC-relative.
            end
        end
    end

endmodule

// File: design/ex_result_reg.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_result_reg (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  ex_pipe_pkg::result_t next_result,
    input  ex_pipe_pkg::flags_t  next_flags,
    input  ex_pipe_pkg::branch_t next_branch,
    output ex_pipe_pkg::result_t result,
    output ex_pipe_pkg::flags_t  flags,
    output ex_pipe_pkg::branch_t branch
);

    // Execute to write-back stage.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            result <= '0;
            branch <= '0;
        end else begin
            result <= next_result;
            branch <= next_branch;
        end
    end

    // Architectural flags.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst)
            flags <= '0;
        else
            flags <= next_flags;  // ALU holds them when idle.
    end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    input  logic                  instr_valid,
    input  ex_isa_pkg::instr_u    instr,
    input  logic [`EX_DATA_W-1:0] pc,
    output ex_pipe_pkg::result_t  result,
    output ex_pipe_pkg::branch_t  branch,
    output ex_pipe_pkg::flags_t   flags
);
    ex_pipe_pkg::operands_t operands;
    ex_pipe_pkg::result_t   next_result;
    ex_pipe_pkg::flags_t    next_flags;
    ex_pipe_pkg::branch_t   next_branch;

    ex_regfile regfile_i (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .instr    (instr),
        .wb       (result),  // Write-back and bypass source.
        .operands (operands)
    );

    ex_alu alu_i (
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .operands    (operands),
        .flags       (flags),
        .next_result (next_result),
        .next_flags  (next_flags),
        .next_branch (next_branch)
    );

    ex_result_reg result_reg_i (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .next_result (next_result),
        .next_flags  (next_flags),
        .next_branch (next_branch),
        .result      (result),
        .flags       (flags),
        .branch      (branch)
    );

endmodule

// File: sim/ex_stage_asserts.sv
`timescale 1ns/1ps

module ex_stage_asserts (
    input logic                 iw_clk,
    input logic                 iw_rst,
    input logic                 instr_valid,
    input ex_pipe_pkg::result_t result,
    input ex_pipe_pkg::branch_t branch,
    input ex_pipe_pkg::flags_t  flags
);

    // A branch only comes out of a strobed JCC.
    a_branch_needs_strobe: assert property (
        @(posedge iw_clk) disable iff (iw_rst) branch.taken |-> $past(instr_valid)
    ) else $error("branch taken without a strobe in the previous cycle");

    a_we_needs_valid: assert property (
        @(posedge iw_clk) disable iff (iw_rst) result.we |-> result.valid
    ) else $error("result write enable without result valid");

    a_flags_hold: assert property (
        @(posedge iw_clk) disable iff (iw_rst) !$past(instr_valid) |-> $stable(flags)
    ) else $error("flags changed after a cycle without a strobe");  // Idle cycles hold.

endmodule

bind ex_stage ex_stage_asserts ex_stage_asserts_i (
    .iw_clk      (iw_clk),
    .iw_rst      (iw_rst),
    .instr_valid (instr_valid),
    .result      (result),
    .branch      (branch),
    .flags       (flags)
);

// File: sim/ex_stage_tb.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_tb;

    localparam int SMAX = (1 << (`EX_DATA_W - 1)) - 1;
    localparam int SMIN = -(1 << (`EX_DATA_W - 1));

    typedef struct packed {
        ex_pipe_pkg::result_t res;
        ex_pipe_pkg::branch_t br;
        ex_pipe_pkg::flags_t  fl;
        logic [31:0]          due;
    } expect_t;

    logic                  iw_clk;
    logic                  iw_rst;
    logic                  instr_valid;
    ex_isa_pkg::instr_u    instr;
    logic [`EX_DATA_W-1:0] pc;
    ex_pipe_pkg::result_t  result;
    ex_pipe_pkg::branch_t  branch;
    ex_pipe_pkg::flags_t   flags;

    logic [`EX_DATA_W-1:0] model_regs [`EX_REG_CNT];
    ex_pipe_pkg::flags_t   model_flags;
    expect_t               exp_q [$];
    logic [31:0]           cycle_cnt;
    logic [31:0]           rnd;
    integer                seed;

    ex_isa_pkg::opcode_e reg_ops [11] = '{ex_isa_pkg::OPC_MOV, ex_isa_pkg::OPC_ADD,
        ex_isa_pkg::OPC_SUB, ex_isa_pkg::OPC_AND, ex_isa_pkg::OPC_OR, ex_isa_pkg::OPC_XOR,
        ex_isa_pkg::OPC_SHL, ex_isa_pkg::OPC_SHR, ex_isa_pkg::OPC_CMP, ex_isa_pkg::OPC_ADDS,
        ex_isa_pkg::OPC_SUBS};
    ex_isa_pkg::opcode_e imm_ops [10] = '{ex_isa_pkg::OPC_MOVI, ex_isa_pkg::OPC_ADDI,
        ex_isa_pkg::OPC_SUBI, ex_isa_pkg::OPC_ANDI, ex_isa_pkg::OPC_ORI, ex_isa_pkg::OPC_XORI,
        ex_isa_pkg::OPC_CMPI, ex_isa_pkg::OPC_MOVIS, ex_isa_pkg::OPC_ADDIS,
        ex_isa_pkg::OPC_SUBIS};

    ex_stage ex_stage_i (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .result      (result),
        .branch      (branch),
        .flags       (flags)
    );

    always #5 iw_clk = ~iw_clk;

    always @(posedge iw_clk) cycle_cnt <= cycle_cnt + 1;

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
        fail_now($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    function automatic ex_isa_pkg::instr_u make_r(ex_isa_pkg::opcode_e op, logic [3:0] tgt,
                                                  logic [3:0] src, logic [3:0] cc);
        ex_isa_pkg::instr_u u;
        u          = '0;
        u.r.opcode = op;
        u.r.tgt    = tgt;
        u.r.src    = src;
        u.r.cc     = ex_isa_pkg::cc_e'(cc);
        return u;
    endfunction

    function automatic ex_isa_pkg::instr_u make_i(ex_isa_pkg::opcode_e op, logic [3:0] tgt,
                                                  logic [`EX_IMM_W-1:0] imm);
        ex_isa_pkg::instr_u u;
        u          = '0;
        u.i.opcode = op;
        u.i.tgt    = tgt;
        u.i.imm    = imm;
        return u;
    endfunction

    function automatic logic cc_holds(ex_isa_pkg::cc_e cc, ex_pipe_pkg::flags_t f);
        case (cc)
            ex_isa_pkg::CC_RA: return 1'b1;
            ex_isa_pkg::CC_EQ: return f.z;
            ex_isa_pkg::CC_NE: return !f.z;
            ex_isa_pkg::CC_LT: return f.n != f.v;
            ex_isa_pkg::CC_GT: return !f.z && (f.n == f.v);
            ex_isa_pkg::CC_GE: return f.n == f.v;
            ex_isa_pkg::CC_LE: return f.z || (f.n != f.v);
            ex_isa_pkg::CC_BT: return f.c;
            ex_isa_pkg::CC_AT: return !f.c && !f.z;
            ex_isa_pkg::CC_BE: return f.c || f.z;
            ex_isa_pkg::CC_AE: return !f.c;
            default:           return 1'b0;
        endcase
    endfunction

    // One instruction through the model.
    function automatic expect_t ex_ref_step(ex_isa_pkg::instr_u ins, logic vld,
                                            logic [`EX_DATA_W-1:0] ins_pc);
        expect_t               e;
        ex_pipe_pkg::flags_t   f;
        logic [`EX_DATA_W-1:0] a;
        logic [`EX_DATA_W-1:0] b;
        logic [`EX_DATA_W-1:0] r;
        int                    sr;
        e    = '0;
        e.fl = model_flags;
        if (!vld)
            return e;
        f  = model_flags;
        a  = model_regs[ins.r.tgt];
        b  = model_regs[ins.r.src];
        r  = '0;
        sr = 0;
        case (ins.i.opcode)
            ex_isa_pkg::OPC_MOVI, ex_isa_pkg::OPC_ADDI, ex_isa_pkg::OPC_SUBI,
            ex_isa_pkg::OPC_ANDI, ex_isa_pkg::OPC_ORI, ex_isa_pkg::OPC_XORI,
            ex_isa_pkg::OPC_CMPI: b = {{(`EX_DATA_W-`EX_IMM_W){1'b0}}, ins.i.imm};
            ex_isa_pkg::OPC_MOVIS, ex_isa_pkg::OPC_ADDIS, ex_isa_pkg::OPC_SUBIS:
                b = {{(`EX_DATA_W-`EX_IMM_W){ins.i.imm[`EX_IMM_W-1]}}, ins.i.imm};
            default: ;
        endcase
        e.res.valid = 1'b1;
        e.res.we    = 1'b1;
        e.res.tgt   = ins.r.tgt;
        case (ins.r.opcode)
            ex_isa_pkg::OPC_MOV, ex_isa_pkg::OPC_MOVI, ex_isa_pkg::OPC_MOVIS: r = b;
            ex_isa_pkg::OPC_ADD, ex_isa_pkg::OPC_ADDI: begin
                r   = a + b;
                f.c = r < a;  // Sum wrapped.
            end
            ex_isa_pkg::OPC_SUB, ex_isa_pkg::OPC_SUBI,
            ex_isa_pkg::OPC_CMP, ex_isa_pkg::OPC_CMPI: begin
                r   = a - b;
                f.c = a < b;
            end
            ex_isa_pkg::OPC_AND, ex_isa_pkg::OPC_ANDI: r = a & b;
            ex_isa_pkg::OPC_OR, ex_isa_pkg::OPC_ORI:   r = a | b;
            ex_isa_pkg::OPC_XOR, ex_isa_pkg::OPC_XORI: r = a ^ b;
            ex_isa_pkg::OPC_SHL: r = a << b;
            ex_isa_pkg::OPC_SHR: r = a >> b;
            ex_isa_pkg::OPC_ADDS, ex_isa_pkg::OPC_ADDIS: sr = $signed(a) + $signed(b);
            ex_isa_pkg::OPC_SUBS, ex_isa_pkg::OPC_SUBIS: sr = $signed(a) - $signed(b);
            default: ;
        endcase
        case (ins.r.opcode)
            ex_isa_pkg::OPC_ADDS, ex_isa_pkg::OPC_ADDIS,
            ex_isa_pkg::OPC_SUBS, ex_isa_pkg::OPC_SUBIS: begin
                r   = sr[`EX_DATA_W-1:0];
                f.n = r[`EX_DATA_W-1];
                f.v = (sr > SMAX) || (sr < SMIN);  // Out of signed range.
            end
            ex_isa_pkg::OPC_MOVIS: begin
                f.n = r[`EX_DATA_W-1];
                f.v = 1'b0;
            end
            ex_isa_pkg::OPC_SHL, ex_isa_pkg::OPC_SHR: f.v = b >= `EX_DATA_W;
            ex_isa_pkg::OPC_CMP, ex_isa_pkg::OPC_CMPI: e.res.we = 1'b0;
            ex_isa_pkg::OPC_JCC: begin
                e.res.we    = 1'b0;
                e.br.taken  = cc_holds(ins.r.cc, f);
                e.br.pc     = ins_pc + b;
            end
            default: ;
        endcase
        if (ins.r.opcode != ex_isa_pkg::OPC_JCC)
            f.z = r == '0;
        if (e.res.we)
            model_regs[ins.r.tgt] = r;
        e.res.data  = r;
        e.fl        = f;
        model_flags = f;
        return e;
    endfunction

    task automatic issue(ex_isa_pkg::instr_u ins, logic vld);
        expect_t     e;
        logic [31:0] r;
        @(posedge iw_clk);
        #1;
        r           = $random(seed);
        instr_valid = vld;
        instr       = ins;
        pc          = r[`EX_DATA_W-1:0];
        e           = ex_ref_step(ins, vld, pc);
        e.due       = cycle_cnt + 1;  // Visible after the next edge.
        exp_q.push_back(e);
    endtask

    // Set flags and then try every condition.
    task automatic jcc_sweep(ex_isa_pkg::opcode_e op, logic [3:0] tgt, logic [3:0] src);
        issue(make_r(op, tgt, src, 4'd0), 1'b1);
        for (int c = 0; c <= ex_isa_pkg::CC_AE; c++) begin
            issue(make_r(ex_isa_pkg::OPC_JCC, 4'd0, 4'd7, c[3:0]), 1'b1);
        end
    endtask

    always @(negedge iw_clk) begin : compare
        expect_t e;
        if (!iw_rst && exp_q.size() > 0 && exp_q[0].due == cycle_cnt) begin
            e = exp_q.pop_front();
            assert (result.valid == e.res.valid)
                else value_error("result.valid", result.valid, e.res.valid);
            assert (result.we == e.res.we)
                else value_error("result.we", result.we, e.res.we);
            if (e.res.we) begin
                assert (result.tgt == e.res.tgt)
                    else value_error("result.tgt", result.tgt, e.res.tgt);
                assert (result.data == e.res.data)
                    else value_error("result.data", result.data, e.res.data);
            end
            assert (branch.taken == e.br.taken)
                else value_error("branch.taken", branch.taken, e.br.taken);
            if (e.br.taken) begin
                assert (branch.pc == e.br.pc)
                    else value_error("branch.pc", branch.pc, e.br.pc);
            end
            assert (flags == e.fl)
                else value_error("flags", flags, e.fl);
        end
    end

    initial begin : stimulus
        iw_clk       = 1'b0;
        iw_rst       = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        cycle_cnt    = '0;
        seed         = 99;
        model_flags  = '0;
        for (int i = 0; i < `EX_REG_CNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge iw_clk);
        #1;
        iw_rst = 1'b0;
        assert (!result.valid && !result.we && !branch.taken && flags == '0)
            else fail_now("outputs are not cleared after reset");
        issue(make_r(ex_isa_pkg::OPC_MOV, 4'd3, 4'd9, 4'd0), 1'b1);
        issue('0, 1'b0);

        // Mostly back to back on eight registers so operands depend often.
        for (int k = 0; k < 300; k++) begin
            rnd = $random(seed);
            if (rnd[26:24] == 3'd0)
                issue('0, 1'b0);
            else if (rnd[31])
                issue(make_i(imm_ops[rnd[30:27] % 10], {1'b0, rnd[2:0]}, rnd[14:3]), 1'b1);
            else
                issue(make_r(reg_ops[rnd[30:27] % 11], {1'b0, rnd[2:0]}, {1'b0, rnd[5:3]},
                             4'd0), 1'b1);
        end

        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd5, 12'h8a5), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVIS, 4'd6, 12'h8a5), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd1, 12'h005), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd2, 12'd24), 1'b1);
        issue(make_r(ex_isa_pkg::OPC_SHL, 4'd1, 4'd2, 4'd0), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd2, 12'd40), 1'b1);
        issue(make_r(ex_isa_pkg::OPC_SHR, 4'd5, 4'd2, 4'd0), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd3, 12'h7ff), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd4, 12'd12), 1'b1);
        issue(make_r(ex_isa_pkg::OPC_SHL, 4'd3, 4'd4, 4'd0), 1'b1);
        issue(make_r(ex_isa_pkg::OPC_ADDS, 4'd3, 4'd3, 4'd0), 1'b1);  // Large positives.

        issue(make_i(ex_isa_pkg::OPC_MOVIS, 4'd7, 12'hf80), 1'b1);  // Backward offset.
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd8, 12'h100), 1'b1);
        issue(make_i(ex_isa_pkg::OPC_MOVI, 4'd9, 12'h200), 1'b1);
        issue(make_r(ex_isa_pkg::OPC_SUBS, 4'd10, 4'd9, 4'd0), 1'b1);
        jcc_sweep(ex_isa_pkg::OPC_CMP, 4'd8, 4'd9);
        jcc_sweep(ex_isa_pkg::OPC_CMP, 4'd9, 4'd8);
        jcc_sweep(ex_isa_pkg::OPC_CMP, 4'd8, 4'd8);
        jcc_sweep(ex_isa_pkg::OPC_SUB, 4'd9, 4'd8);
        issue(make_r(ex_isa_pkg::OPC_MOV, 4'd11, 4'd9, 4'd0), 1'b1);
        issue(make_r(ex_isa_pkg::OPC_MOV, 4'd12, 4'd0, 4'd0), 1'b1);  // JCC target register.
        issue('0, 1'b0);
        issue('0, 1'b0);

        for (int t = 0; t < 50 && exp_q.size() > 0; t++) begin
            @(posedge iw_clk);
        end
        if (exp_q.size() > 0) begin
            fail_now("timeout while waiting for the last results");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+design
design/ex_isa_pkg.sv
design/ex_pipe_pkg.sv
design/ex_regfile.sv
design/ex_alu.sv
design/ex_result_reg.sv
design/ex_stage.sv
sim/ex_stage_asserts.sv
sim/ex_stage_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - design
    files:
      - design/ex_isa_pkg.sv
      - design/ex_pipe_pkg.sv
      - design/ex_regfile.sv
      - design/ex_alu.sv
      - design/ex_result_reg.sv
      - design/ex_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/ex_stage_asserts.sv
      - sim/ex_stage_tb.sv
